// File: Bender.yml
package:
  name: rv_front

sources:
  # RTL of the front end, package first
  - target: rtl
    files:
      - hw/rv_front_pkg.sv
      - hw/imem.sv
      - hw/fetch.sv
      - hw/igen.sv
      - hw/decode.sv
      - hw/register_file.sv
      - hw/rv_front_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/rv_front_props.sv
      - bench/rv_front_tb.sv

// File: bench/rv_front_props.sv
/*
 * Concurrent checks on the fetch unit
 * Bound into every fetch instance of the front end
 */

module rv_front_props #(
    parameter int                AWIDTH   = 32,
    parameter logic [AWIDTH-1:0] RESET_PC = '0
)(
    input logic              clk,
    input logic              rst_n_i,
    input logic              stall_i,
    input logic              redirect_i,
    input logic [AWIDTH-1:0] redirect_target_i,
    input logic [AWIDTH-1:0] pc_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // First cycle out of reset starts at the reset vector
    reset_pc_a: assert property (@(posedge clk) $rose(rst_n_i) |-> pc_o == RESET_PC)
        else $error("PC differs from the reset vector after reset release");

    // Redirect wins over everything
    redirect_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i |=> pc_o == $past(redirect_target_i))
        else $error("PC did not load the redirect target");

    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i && !redirect_i |=> pc_o == $past(pc_o))
        else $error("PC moved during a stall");

    // An aligned PC stays aligned unless a redirect brings a misaligned target
    align_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (pc_o[1:0] == 2'b00 && !(redirect_i && redirect_target_i[1:0] != 2'b00))
        |=> pc_o[1:0] == 2'b00)
        else $error("PC lost word alignment");

endmodule : rv_front_props

bind fetch rv_front_props #(
    .AWIDTH   (AWIDTH),
    .RESET_PC (RESET_PC)
) props0 (.*);

// File: bench/rv_front_tb.sv
/*
 * Testbench of the RV32I front end
 * Loads a table of instructions during reset, then checks fetch, decode,
 * stall and redirect, and the register file with random write-back
 */

module rv_front_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          DWIDTH       = 32;
    localparam int          AWIDTH       = 32;
    localparam logic [31:0] RESET_PC     = 32'h0;
    localparam int          IMEM_DEPTH   = 64;
    localparam int          PERIOD       = 40;
    localparam int          RESET_CYCLES = 10;
    localparam int          N_ENTRIES    = 11;  // One more than the reset cycles
    localparam int          RF_TRIALS    = 8;
    localparam int          SCRATCH_WORD = 20;  // Word used for register read-back

    // Instruction word and expected decode
    typedef struct packed {
        logic [31:0] insn;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  shamt;
        logic [31:0] imm;
    } entry_t;

    entry_t insn_tab [N_ENTRIES] = '{
        '{32'h407302B3, 5'd5,  5'd6,  5'd7,  3'd0, 7'h20, 5'd0,  32'h00000000}, // sub x5,x6,x7
        '{32'hFFB10093, 5'd1,  5'd2,  5'd0,  3'd0, 7'h00, 5'd0,  32'hFFFFFFFB}, // addi x1,x2,-5
        '{32'h4074D213, 5'd4,  5'd9,  5'd0,  3'd5, 7'h20, 5'd7,  32'h00000407}, // srai x4,x9,7
        '{32'h01052403, 5'd8,  5'd10, 5'd0,  3'd2, 7'h00, 5'd0,  32'h00000010}, // lw x8,16(x10)
        '{32'hFEB62A23, 5'd0,  5'd12, 5'd11, 3'd2, 7'h00, 5'd0,  32'hFFFFFFF4}, // sw x11,-12(x12)
        '{32'hFEE68CE3, 5'd0,  5'd13, 5'd14, 3'd0, 7'h00, 5'd0,  32'hFFFFFFF8}, // beq back by 8
        '{32'hABCDE7B7, 5'd15, 5'd0,  5'd0,  3'd0, 7'h00, 5'd0,  32'hABCDE000}, // lui
        '{32'h12345817, 5'd16, 5'd0,  5'd0,  3'd0, 7'h00, 5'd0,  32'h12345000}, // auipc
        '{32'h001000EF, 5'd1,  5'd0,  5'd0,  3'd0, 7'h00, 5'd0,  32'h00000800}, // jal x1,+2048
        '{32'h00408067, 5'd0,  5'd1,  5'd0,  3'd0, 7'h00, 5'd0,  32'h00000004}, // jalr x0,4(x1)
        '{32'hA5A5A57F, 5'h0A, 5'h0B, 5'h1A, 3'd2, 7'h52, 5'h1A, 32'h00000000}  // Unknown opcode
    };

    logic              clk;
    logic              rst_n;
    logic              imem_we;
    logic [5:0]        imem_waddr;
    logic [31:0]       imem_wdata;
    logic              stall;
    logic              redirect;
    logic [31:0]       redirect_target;
    logic              wb_en;
    logic [4:0]        wb_rd;
    logic [31:0]       wb_data;
    logic [31:0]       pc_o;
    logic [31:0]       insn_o;
    logic [6:0]        opcode_o;
    logic [4:0]        rd_o;
    logic [4:0]        rs1_o;
    logic [4:0]        rs2_o;
    logic [6:0]        funct7_o;
    logic [2:0]        funct3_o;
    logic [4:0]        shamt_o;
    logic [31:0]       imm_o;
    logic [31:0]       rs1_data_o;
    logic [31:0]       rs2_data_o;

    int err_count   = 0;
    int tests_run   = 0;
    int tests_fail  = 0;

    rv_front_top #(
        .DWIDTH     (DWIDTH),
        .AWIDTH     (AWIDTH),
        .RESET_PC   (RESET_PC),
        .IMEM_DEPTH (IMEM_DEPTH)
    ) dut0 (
        .clk               (clk),
        .rst_n_i           (rst_n),
        .imem_we_i         (imem_we),
        .imem_waddr_i      (imem_waddr),
        .imem_wdata_i      (imem_wdata),
        .stall_i           (stall),
        .redirect_i        (redirect),
        .redirect_target_i (redirect_target),
        .wb_en_i           (wb_en),
        .wb_rd_i           (wb_rd),
        .wb_data_i         (wb_data),
        .pc_o              (pc_o),
        .insn_o            (insn_o),
        .opcode_o          (opcode_o),
        .rd_o              (rd_o),
        .rs1_o             (rs1_o),
        .rs2_o             (rs2_o),
        .funct7_o          (funct7_o),
        .funct3_o          (funct3_o),
        .shamt_o           (shamt_o),
        .imm_o             (imm_o),
        .rs1_data_o        (rs1_data_o),
        .rs2_data_o        (rs2_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Watchdog for the whole run
    initial begin
        repeat (1000) @(posedge clk);
        $display("Run did not complete within 1000 cycles");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("Test %s: ok", name);
        end else begin
            tests_fail++;
            $display("Test %s: %0d errors", name, errs);
        end
    endtask

    // Outputs settle a quarter period after the falling edge
    task automatic settle();
        #(PERIOD / 4);
    endtask

    task automatic wait_for_pc(input logic [31:0] target, input int max_cycles);
        int n;
        n = 0;
        while (pc_o !== target && n < max_cycles) begin
            @(negedge clk);
            settle();
            n++;
        end
        if (pc_o !== target) begin
            $display("Timed out waiting for the PC to reach 0x%08h", target);
            err_count++;
        end
    endtask

    // R-type word that reads rs1 and rs2
    function automatic logic [31:0] rtype_word(input logic [4:0] rd,
                                               input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, rv_front_pkg::OPCODE_RTYPE};
    endfunction

    task automatic check_fields(input int i);
        check_val("opcode_o", {25'b0, opcode_o}, {25'b0, insn_tab[i].insn[6:0]});
        check_val("rd_o", {27'b0, rd_o}, {27'b0, insn_tab[i].rd});
        check_val("rs1_o", {27'b0, rs1_o}, {27'b0, insn_tab[i].rs1});
        check_val("rs2_o", {27'b0, rs2_o}, {27'b0, insn_tab[i].rs2});
        check_val("funct3_o", {29'b0, funct3_o}, {29'b0, insn_tab[i].f3});
        check_val("funct7_o", {25'b0, funct7_o}, {25'b0, insn_tab[i].f7});
        check_val("shamt_o", {27'b0, shamt_o}, {27'b0, insn_tab[i].shamt});
        check_val("imm_o", imm_o, insn_tab[i].imm);
    endtask

    initial begin
        int          e0;
        int          fetch_errs;
        int          decode_errs;
        int          stall_len;
        logic [31:0] held_pc;
        logic [31:0] held_insn;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] shadow [32];   // Expected register contents

        void'($urandom(22092));
        rst_n           = 1'b0;
        imem_we         = 1'b0;
        imem_waddr      = '0;
        imem_wdata      = '0;
        stall           = 1'b0;
        redirect        = 1'b0;
        redirect_target = '0;
        wb_en           = 1'b0;
        wb_rd           = '0;
        wb_data         = '0;
        fetch_errs      = 0;
        decode_errs     = 0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end

        // Program load while reset is held
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_waddr = 6'(c);
            imem_wdata = insn_tab[c].insn;
        end
        @(negedge clk);
        rst_n      = 1'b1;
        imem_waddr = 6'(RESET_CYCLES);               // Last word, fetched much later
        imem_wdata = insn_tab[RESET_CYCLES].insn;
        settle();

        e0 = err_count;
        check_val("pc_o", pc_o, RESET_PC);
        check_val("rs1_data_o", rs1_data_o, 32'h0);
        check_val("rs2_data_o", rs2_data_o, 32'h0);
        report_test("reset", err_count - e0);

        // One table entry per cycle
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (i > 0) begin
                @(negedge clk);
                imem_we = 1'b0;
                settle();
            end
            e0 = err_count;
            check_val("pc_o", pc_o, RESET_PC + 32'(4 * i));
            check_val("insn_o", insn_o, insn_tab[i].insn);
            fetch_errs += err_count - e0;
            e0 = err_count;
            check_fields(i);
            decode_errs += err_count - e0;
        end
        report_test("sequential fetch", fetch_errs);
        report_test("decode", decode_errs);

        // Park on a loaded word, stall for a random length, then redirect under stall
        e0 = err_count;
        stall_len = 2 + int'($urandom % 5);
        held_pc   = RESET_PC + 32'd20;               // Word 5
        held_insn = insn_tab[5].insn;
        @(negedge clk);
        redirect        = 1'b1;
        redirect_target = held_pc;
        @(negedge clk);
        redirect = 1'b0;
        stall    = 1'b1;
        settle();
        check_val("pc_o", pc_o, held_pc);
        for (int s = 0; s < stall_len; s++) begin
            @(negedge clk);
            settle();
            check_val("pc_o", pc_o, held_pc);
            check_val("insn_o", insn_o, held_insn);
        end
        @(negedge clk);
        redirect        = 1'b1;
        redirect_target = RESET_PC + 32'd12;
        @(negedge clk);
        redirect = 1'b0;
        settle();
        check_val("pc_o", pc_o, RESET_PC + 32'd12);
        check_val("insn_o", insn_o, insn_tab[3].insn);
        @(negedge clk);
        stall = 1'b0;
        settle();
        check_val("pc_o", pc_o, RESET_PC + 32'd12);   // Still held by the last stall edge
        @(negedge clk);
        settle();
        check_val("pc_o", pc_o, RESET_PC + 32'd16);
        report_test("stall and redirect", err_count - e0);

        // Random write-back, read through a parked R-type word
        e0 = err_count;
        for (int t = 0; t < RF_TRIALS; t++) begin
            r1 = 5'(1 + $urandom % 31);
            r2 = 5'(1 + $urandom % 31);
            d1 = $urandom;
            d2 = $urandom;
            @(negedge clk);
            stall           = 1'b0;
            redirect        = 1'b1;
            redirect_target = RESET_PC + 32'(4 * SCRATCH_WORD);
            imem_we         = 1'b1;
            imem_waddr      = 6'(SCRATCH_WORD);
            imem_wdata      = rtype_word(5'd1, r1, r2);
            @(negedge clk);
            redirect = 1'b0;
            stall    = 1'b1;
            imem_we  = 1'b0;
            wb_en    = 1'b1;
            wb_rd    = r1;
            wb_data  = d1;
            settle();
            wait_for_pc(RESET_PC + 32'(4 * SCRATCH_WORD), 2);
            check_val("rs1_data_o", rs1_data_o, d1);              // Bypass
            check_val("rs2_data_o", rs2_data_o, (r2 == r1) ? d1 : shadow[r2]);
            shadow[r1] = d1;
            @(negedge clk);
            wb_rd   = r2;
            wb_data = d2;
            settle();
            check_val("rs1_data_o", rs1_data_o, (r1 == r2) ? d2 : shadow[r1]);
            check_val("rs2_data_o", rs2_data_o, d2);
            shadow[r2] = d2;
            @(negedge clk);
            wb_en = 1'b0;
            settle();
            check_val("rs1_data_o", rs1_data_o, shadow[r1]);       // From storage
            check_val("rs2_data_o", rs2_data_o, shadow[r2]);
        end

        // x0 ignores writes, pending or stored
        @(negedge clk);
        redirect   = 1'b1;
        imem_we    = 1'b1;
        imem_wdata = rtype_word(5'd1, 5'd0, 5'd0);
        @(negedge clk);
        redirect = 1'b0;
        imem_we  = 1'b0;
        wb_en    = 1'b1;
        wb_rd    = 5'd0;
        wb_data  = $urandom | 32'h1;
        settle();
        check_val("rs1_data_o", rs1_data_o, 32'h0);
        check_val("rs2_data_o", rs2_data_o, 32'h0);
        @(negedge clk);
        wb_en = 1'b0;
        settle();
        check_val("rs1_data_o", rs1_data_o, 32'h0);
        report_test("register file", err_count - e0);

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_fail, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : rv_front_tb

// File: hw/decode.sv
/*
 * Decode stage
 * Splits the fetched word into register indices, function codes,
 * shift amount and immediate, driving unused fields of a format to zero
 */

module decode #(
    parameter int DWIDTH = 32,
    parameter int AWIDTH = 32
)(
    input  logic [DWIDTH-1:0]                   insn_i,
    input  logic [AWIDTH-1:0]                   pc_i,
    output logic [AWIDTH-1:0]                   pc_o,
    output logic [DWIDTH-1:0]                   insn_o,
    output logic [6:0]                          opcode_o,   // Raw opcode bits
    output logic [rv_front_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [rv_front_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rv_front_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [6:0]                          funct7_o,
    output logic [2:0]                          funct3_o,
    output logic [4:0]                          shamt_o,    // Shift amount
    output logic [DWIDTH-1:0]                   imm_o
);

    rv_front_pkg::opcode_e opcode;
    logic                  is_shift;   // OP-IMM shift form

    assign opcode = rv_front_pkg::opcode_e'(insn_i[6:0]);

    assign is_shift = (insn_i[14:12] == rv_front_pkg::FUNCT3_SLL) ||
                      (insn_i[14:12] == rv_front_pkg::FUNCT3_SRL_SRA);

    // Immediate per format
    igen #(
        .DWIDTH (DWIDTH)
    ) u_igen (
        .insn_i (insn_i),
        .imm_o  (imm_o)
    );

    // Always passed through
    assign pc_o     = pc_i;
    assign insn_o   = insn_i;
    assign opcode_o = insn_i[6:0];

    always_comb begin
        // Nothing kept unless the format uses it
        rd_o     = '0;
        rs1_o    = '0;
        rs2_o    = '0;
        funct7_o = '0;
        funct3_o = '0;
        shamt_o  = '0;

        case (opcode)
            rv_front_pkg::OPCODE_RTYPE: begin
                rd_o     = insn_i[11:7];
                rs1_o    = insn_i[19:15];
                rs2_o    = insn_i[24:20];
                funct3_o = insn_i[14:12];
                funct7_o = insn_i[31:25];   // ADD/SUB, SRL/SRA select
            end

            rv_front_pkg::OPCODE_ITYPE,
            rv_front_pkg::OPCODE_LOAD,
            rv_front_pkg::OPCODE_JALR: begin
                rd_o     = insn_i[11:7];
                rs1_o    = insn_i[19:15];   // ALU operand or base address
                funct3_o = insn_i[14:12];
                // Shifts reuse the immediate field
                if (opcode == rv_front_pkg::OPCODE_ITYPE && is_shift) begin
                    funct7_o = insn_i[31:25];
                    shamt_o  = insn_i[24:20];
                end
            end

            rv_front_pkg::OPCODE_STORE,
            rv_front_pkg::OPCODE_BRANCH: begin
                rs1_o    = insn_i[19:15];   // Base or first compare operand
                rs2_o    = insn_i[24:20];   // Store data or second operand
                funct3_o = insn_i[14:12];   // Width or branch condition
            end

            rv_front_pkg::OPCODE_LUI,
            rv_front_pkg::OPCODE_AUIPC,
            rv_front_pkg::OPCODE_JAL: begin
                rd_o = insn_i[11:7];        // Only a destination
            end

            default: begin
                // Unknown encoding, expose every raw field
                rd_o     = insn_i[11:7];
                rs1_o    = insn_i[19:15];
                rs2_o    = insn_i[24:20];
                funct3_o = insn_i[14:12];
                funct7_o = insn_i[31:25];
                shamt_o  = insn_i[24:20];
            end
        endcase
    end

endmodule : decode

// File: hw/fetch.sv
/*
 * Program counter unit
 * Steps the PC by one word per cycle, holds it while stalled and
 * loads a new target on a one-cycle redirect strobe
 */

module fetch #(
    parameter int                AWIDTH   = 32,
    parameter logic [AWIDTH-1:0] RESET_PC = '0
)(
    input  logic              clk,
    input  logic              rst_n_i,           // Synchronous, active low
    input  logic              stall_i,           // Level, hold the PC
    input  logic              redirect_i,        // One-cycle strobe
    input  logic [AWIDTH-1:0] redirect_target_i,
    output logic [AWIDTH-1:0] pc_o
);

    logic [AWIDTH-1:0] pc_q;
    logic [AWIDTH-1:0] pc_next;

    // Next PC selection
    // Redirect beats stall, stall beats the sequential step
    always_comb begin
        if (redirect_i) begin
            pc_next = redirect_target_i;
        end else if (stall_i) begin
            pc_next = pc_q;                   // Hold
        end else begin
            pc_next = pc_q + AWIDTH'(4);      // Next word
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule : fetch

// File: hw/igen.sv
/*
 * Immediate generator
 * Assembles the immediate of the I, S, B, U and J formats from the
 * instruction word, sign-extended from bit 31 to DWIDTH
 */

module igen #(
    parameter int DWIDTH = 32
)(
    input  logic [DWIDTH-1:0] insn_i,
    output logic [DWIDTH-1:0] imm_o
);

    rv_front_pkg::opcode_e opcode;
    logic signed [31:0]    imm32;   // 32-bit immediate before widening

    assign opcode = rv_front_pkg::opcode_e'(insn_i[6:0]);

    always_comb begin
        case (opcode)
            // I-type, 12 bits at the top of the word
            rv_front_pkg::OPCODE_ITYPE,
            rv_front_pkg::OPCODE_LOAD,
            rv_front_pkg::OPCODE_JALR:
                imm32 = {{20{insn_i[31]}}, insn_i[31:20]};
            // S-type, split around rs2 and rs1
            rv_front_pkg::OPCODE_STORE:
                imm32 = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
            // B-type, halfword offset
            rv_front_pkg::OPCODE_BRANCH:
                imm32 = {{19{insn_i[31]}}, insn_i[31], insn_i[7],
                         insn_i[30:25], insn_i[11:8], 1'b0};
            // U-type, upper 20 bits
            rv_front_pkg::OPCODE_LUI,
            rv_front_pkg::OPCODE_AUIPC:
                imm32 = {insn_i[31:12], 12'b0};
            // J-type, 21-bit jump offset
            rv_front_pkg::OPCODE_JAL:
                imm32 = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12],
                         insn_i[20], insn_i[30:21], 1'b0};
            default:
                imm32 = '0;   // R-type and unknown opcodes carry no immediate
        endcase
    end

    // Signed source, so the size cast sign-extends for wider data paths
    assign imm_o = DWIDTH'(imm32);

endmodule : igen

// File: hw/imem.sv
/*
 * Word-addressed instruction memory
 * Loaded through a synchronous write port before the program runs,
 * read combinationally by the word index of the PC
 */

module imem #(
    parameter int DWIDTH     = 32,
    parameter int AWIDTH     = 32,
    parameter int IMEM_DEPTH = 64   // Words, power of two
)(
    input  logic                          clk,
    input  logic                          we_i,    // Load strobe
    input  logic [$clog2(IMEM_DEPTH)-1:0] waddr_i, // Word index
    input  logic [DWIDTH-1:0]             wdata_i,
    input  logic [AWIDTH-1:0]             pc_i,    // Byte address
    output logic [DWIDTH-1:0]             insn_o
);

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    logic [DWIDTH-1:0] mem [IMEM_DEPTH]; // Program storage, no reset

    // Loading port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Drop the byte offset, upper PC bits wrap around
    assign insn_o = mem[pc_i[IDX_W+1:2]];

endmodule : imem

// File: hw/register_file.sv
/*
 * Integer register file
 * Two combinational read ports with same-cycle write bypass and one
 * write port from write-back; x0 always reads zero
 */

module register_file #(
    parameter int DWIDTH = 32
)(
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [rv_front_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_front_pkg::REG_ADDR_W-1:0] rs2_i,
    output logic [DWIDTH-1:0]                   rs1_data_o,
    output logic [DWIDTH-1:0]                   rs2_data_o,
    input  logic                                wb_en_i,     // Level, sampled at the edge
    input  logic [rv_front_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [DWIDTH-1:0]                   wb_data_i
);

    // x1..x31 only, x0 has no storage
    logic [DWIDTH-1:0] regs [1:rv_front_pkg::REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < rv_front_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;   // Writes to x0 dropped
        end
    end

    // One read port, x0 first, then the pending write, then storage
    function automatic logic [DWIDTH-1:0] read_port(
        input logic [rv_front_pkg::REG_ADDR_W-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end else if (wb_en_i && (wb_rd_i == idx)) begin
            return wb_data_i;             // Bypass
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule : register_file

// File: hw/rv_front_pkg.sv
/*
 * Shared definitions for the RV32I front end
 * Holds the major opcode enum, the OP-IMM shift funct3 codes and the
 * register file sizes, referenced by scoped name from the RTL
 */

package rv_front_pkg;

    // RV32I major opcodes, bits [6:0] of every instruction
    typedef enum logic [6:0] {
        OPCODE_RTYPE  = 7'b0110011, // Register-register ALU ops
        OPCODE_ITYPE  = 7'b0010011, // OP-IMM, ALU ops with immediate
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011, // Conditional branches
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_LUI    = 7'b0110111, // Load upper immediate
        OPCODE_AUIPC  = 7'b0010111  // Add upper immediate to PC
    } opcode_e;

    // funct3 codes of the OP-IMM shift forms
    // These carry shamt in [24:20] and funct7 in [31:25]
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101; // funct7[5] picks SRA

    // Integer register file geometry
    localparam int REG_COUNT  = 32;                  // x0..x31
    localparam int REG_ADDR_W = $clog2(REG_COUNT);   // 5-bit register index

endpackage : rv_front_pkg

// File: hw/rv_front_top.sv
/*
 * Front end of the RV32I core
 * Connects fetch, instruction memory, decode and the register file;
 * the program is loaded and write-back driven from outside
 */

module rv_front_top #(
    parameter int                DWIDTH     = 32,
    parameter int                AWIDTH     = 32,
    parameter logic [AWIDTH-1:0] RESET_PC   = '0,
    parameter int                IMEM_DEPTH = 64
)(
    input  logic                                clk,
    input  logic                                rst_n_i,
    // Program loading
    input  logic                                imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0]       imem_waddr_i,
    input  logic [DWIDTH-1:0]                   imem_wdata_i,
    // Fetch control
    input  logic                                stall_i,
    input  logic                                redirect_i,
    input  logic [AWIDTH-1:0]                   redirect_target_i,
    // Write-back
    input  logic                                wb_en_i,
    input  logic [rv_front_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [DWIDTH-1:0]                   wb_data_i,
    // Decoded instruction
    output logic [AWIDTH-1:0]                   pc_o,
    output logic [DWIDTH-1:0]                   insn_o,
    output logic [6:0]                          opcode_o,
    output logic [rv_front_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [rv_front_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rv_front_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [6:0]                          funct7_o,
    output logic [2:0]                          funct3_o,
    output logic [4:0]                          shamt_o,
    output logic [DWIDTH-1:0]                   imm_o,
    // Source operands
    output logic [DWIDTH-1:0]                   rs1_data_o,
    output logic [DWIDTH-1:0]                   rs2_data_o
);

    logic [AWIDTH-1:0] pc;     // Fetch PC into memory and decode
    logic [DWIDTH-1:0] insn;   // Fetched word

    fetch #(
        .AWIDTH   (AWIDTH),
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .redirect_i        (redirect_i),
        .redirect_target_i (redirect_target_i),
        .pc_o              (pc)
    );

    imem #(
        .DWIDTH     (DWIDTH),
        .AWIDTH     (AWIDTH),
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem (
        .clk     (clk),
        .we_i    (imem_we_i),
        .waddr_i (imem_waddr_i),
        .wdata_i (imem_wdata_i),
        .pc_i    (pc),
        .insn_o  (insn)
    );

    decode #(
        .DWIDTH (DWIDTH),
        .AWIDTH (AWIDTH)
    ) u_decode (
        .insn_i   (insn),
        .pc_i     (pc),
        .pc_o     (pc_o),
        .insn_o   (insn_o),
        .opcode_o (opcode_o),
        .rd_o     (rd_o),
        .rs1_o    (rs1_o),
        .rs2_o    (rs2_o),
        .funct7_o (funct7_o),
        .funct3_o (funct3_o),
        .shamt_o  (shamt_o),
        .imm_o    (imm_o)
    );

    // Operand reads follow the decoded source indices
    register_file #(
        .DWIDTH (DWIDTH)
    ) u_register_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (rs1_o),
        .rs2_i      (rs2_o),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o),
        .wb_en_i    (wb_en_i),
        .wb_rd_i    (wb_rd_i),
        .wb_data_i  (wb_data_i)
    );

endmodule : rv_front_top

// File: vlog.f
hw/rv_front_pkg.sv
hw/imem.sv
hw/fetch.sv
hw/igen.sv
hw/decode.sv
hw/register_file.sv
hw/rv_front_top.sv
bench/rv_front_props.sv
bench/rv_front_tb.sv
